/* Makefile */
# Verilator flow for the execution subsystem

VERILATOR ?= verilator
TOP       ?= tb_exu_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass or fail comes from the log, not from the simulator exit code
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
rtl/exu_pkg.sv
rtl/int_rf.sv
rtl/credit_fifo.sv
rtl/issue_stage.sv
rtl/alu_stage.sv
rtl/commit_stage.sv
rtl/exu_top.sv
verif/tb_exu_top.sv

/* rtl/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // From buf_exec
  input  logic                  in_valid_i,
  input  exu_pkg::exec_req_t    in_req_i,
  output logic                  in_pop_o,

  // Toward buf_commit
  output logic                  out_push_o,
  output exu_pkg::commit_req_t  out_req_o,
  input  logic                  out_credit_i
);

  logic [exu_pkg::CREDIT_W-1:0]  credit_q;
  logic [exu_pkg::XLEN-1:0]      result;
  // Shift amount from the low bits of b
  logic [$clog2(exu_pkg::XLEN)-1:0] shamt;

  // Pop and push together, only with room downstream
  assign in_pop_o   = in_valid_i && (credit_q != '0);
  assign out_push_o = in_pop_o;

  assign shamt = in_req_i.b[$clog2(exu_pkg::XLEN)-1:0];

  // ----------------------------------------
  // Execute
  // ----------------------------------------
  always_comb begin
    result = '0;
    case (in_req_i.op)
      exu_pkg::OP_ADD: result = in_req_i.a + in_req_i.b;
      exu_pkg::OP_SUB: result = in_req_i.a - in_req_i.b;
      exu_pkg::OP_AND: result = in_req_i.a & in_req_i.b;
      exu_pkg::OP_OR:  result = in_req_i.a | in_req_i.b;
      exu_pkg::OP_XOR: result = in_req_i.a ^ in_req_i.b;
      exu_pkg::OP_SLL: result = in_req_i.a << shamt;
      exu_pkg::OP_SRL: result = in_req_i.a >> shamt;
      exu_pkg::OP_LI:  result = in_req_i.imm;
      default:         result = '0;
    endcase
  end

  assign out_req_o.rd    = in_req_i.rd;
  assign out_req_o.value = result;

  // Credit counter for buf_commit
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= exu_pkg::CREDIT_W'(exu_pkg::BUF_DEPTH);
    end else if (out_push_o && !out_credit_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (!out_push_o && out_credit_i) begin
      credit_q <= credit_q + 1'b1;
    end
  end

endmodule

/* rtl/commit_stage.sv */
`timescale 1ns/1ps

module commit_stage (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // From buf_commit
  input  logic                             in_valid_i,
  input  exu_pkg::commit_req_t             in_req_i,
  output logic                             in_pop_o,

  // Register file write, also releases the scoreboard
  output logic                             wb_valid_o,
  output logic [exu_pkg::REG_IDX_LEN-1:0]  wb_rd_o,
  output logic [exu_pkg::XLEN-1:0]         wb_value_o,

  // Retire output, valid/ready
  output logic                             retire_valid_o,
  output logic [exu_pkg::REG_IDX_LEN-1:0]  retire_rd_o,
  output logic [exu_pkg::XLEN-1:0]         retire_value_o,
  input  logic                             retire_ready_i
);

  logic load;

  // Load when empty or draining this cycle
  assign load     = in_valid_i && (!retire_valid_o || retire_ready_i);
  assign in_pop_o = load;

  // Write-back happens at the load edge
  assign wb_valid_o = load;
  assign wb_rd_o    = in_req_i.rd;
  assign wb_value_o = in_req_i.value;

  // ----------------------------------------
  // Retire register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      retire_valid_o <= 1'b0;
    end else if (load) begin
      retire_valid_o <= 1'b1;
    end else if (retire_ready_i) begin
      retire_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      retire_rd_o    <= in_req_i.rd;
      retire_value_o <= in_req_i.value;
    end
  end

  // Stalled retire holds valid and data
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (retire_valid_o && !retire_ready_i) |=>
      (retire_valid_o && $stable(retire_rd_o) && $stable(retire_value_o)))
    else $error("retire data changed under back-pressure");

endmodule

/* rtl/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Sender side
  input  logic     push_i,
  input  payload_t data_i,

  // Receiver side
  input  logic     pop_i,
  output logic     valid_o,
  output payload_t data_o,

  // Credit back to the sender
  output logic     credit_o
);

  // Storage and pointers, depth is a power of two so pointers wrap
  payload_t                                 mem_q [0:exu_pkg::BUF_DEPTH-1];
  logic [$clog2(exu_pkg::BUF_DEPTH)-1:0]    wr_ptr_q;
  logic [$clog2(exu_pkg::BUF_DEPTH)-1:0]    rd_ptr_q;
  logic [exu_pkg::CREDIT_W-1:0]             count_q;
  logic                                     full;
  logic                                     do_pop;

  assign full    = (count_q == exu_pkg::CREDIT_W'(exu_pkg::BUF_DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  // Only a real pop frees a slot
  assign do_pop   = pop_i && valid_o;
  assign credit_o = do_pop;

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Net change of push and pop
      if (push_i && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Sender credit accounting must keep pushes within the free slots
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(push_i && full))
    else $error("credit_fifo push while full");
  // Receiver only pops a visible head
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(pop_i && !valid_o))
    else $error("credit_fifo pop while empty");

endmodule

/* rtl/exu_pkg.sv */
package exu_pkg;

  // ----------------------------------------
  // Datapath sizes
  // ----------------------------------------
  localparam int unsigned XLEN        = 32;
  localparam int unsigned XREG_NUM    = 32;
  localparam int unsigned REG_IDX_LEN = 5;

  // ----------------------------------------
  // Credit buffers
  // ----------------------------------------
  // Entries per stage-to-stage buffer
  localparam int unsigned BUF_DEPTH = 4;
  // Counter must hold 0 up to BUF_DEPTH inclusive
  localparam int unsigned CREDIT_W  = 3;

  // ALU operations, OP_LI passes the immediate through
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_SRL = 3'd6,
    OP_LI  = 3'd7
  } alu_op_e;

  // Issue to ALU bundle
  typedef struct packed {
    alu_op_e                op;
    logic [REG_IDX_LEN-1:0] rd;
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic [XLEN-1:0]        imm;
  } exec_req_t;

  // ALU to commit bundle
  typedef struct packed {
    logic [REG_IDX_LEN-1:0] rd;
    logic [XLEN-1:0]        value;
  } commit_req_t;

endpackage

/* rtl/exu_top.sv */
`timescale 1ns/1ps

module exu_top (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // Instruction input
  input  logic                             instr_valid_i,
  input  exu_pkg::alu_op_e                 instr_op_i,
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  instr_rd_i,
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  instr_rs1_i,
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  instr_rs2_i,
  input  logic [exu_pkg::XLEN-1:0]         instr_imm_i,
  output logic                             instr_ready_o,

  // Retire output
  output logic                             retire_valid_o,
  output logic [exu_pkg::REG_IDX_LEN-1:0]  retire_rd_o,
  output logic [exu_pkg::XLEN-1:0]         retire_value_o,
  input  logic                             retire_ready_i
);

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------
  // Issue to buf_exec to ALU
  logic                   ex_push, ex_valid, ex_pop, ex_credit;
  exu_pkg::exec_req_t     ex_req_in, ex_req_out;
  // ALU to buf_commit to commit
  logic                   cm_push, cm_valid, cm_pop, cm_credit;
  exu_pkg::commit_req_t   cm_req_in, cm_req_out;
  // Register file
  logic [exu_pkg::REG_IDX_LEN-1:0]  rs1_idx, rs2_idx, wb_rd;
  logic [exu_pkg::XLEN-1:0]         rs1_value, rs2_value, wb_value;
  logic                             wb_valid;

  issue_stage u_issue (
    .clk_i, .rst_n_i,
    .instr_valid_i, .instr_op_i, .instr_rd_i, .instr_rs1_i, .instr_rs2_i,
    .instr_imm_i, .instr_ready_o,
    .wb_valid_i  (wb_valid),
    .wb_rd_i     (wb_rd),
    .rs1_idx_o   (rs1_idx),
    .rs2_idx_o   (rs2_idx),
    .rs1_value_i (rs1_value),
    .rs2_value_i (rs2_value),
    .push_o      (ex_push),
    .req_o       (ex_req_in),
    .credit_i    (ex_credit)
  );

  credit_fifo #(.payload_t(exu_pkg::exec_req_t)) buf_exec (
    .clk_i, .rst_n_i,
    .push_i (ex_push), .data_i (ex_req_in),
    .pop_i  (ex_pop),  .valid_o (ex_valid), .data_o (ex_req_out),
    .credit_o (ex_credit)
  );

  alu_stage u_alu (
    .clk_i, .rst_n_i,
    .in_valid_i   (ex_valid),
    .in_req_i     (ex_req_out),
    .in_pop_o     (ex_pop),
    .out_push_o   (cm_push),
    .out_req_o    (cm_req_in),
    .out_credit_i (cm_credit)
  );

  credit_fifo #(.payload_t(exu_pkg::commit_req_t)) buf_commit (
    .clk_i, .rst_n_i,
    .push_i (cm_push), .data_i (cm_req_in),
    .pop_i  (cm_pop),  .valid_o (cm_valid), .data_o (cm_req_out),
    .credit_o (cm_credit)
  );

  commit_stage u_commit (
    .clk_i, .rst_n_i,
    .in_valid_i (cm_valid),
    .in_req_i   (cm_req_out),
    .in_pop_o   (cm_pop),
    .wb_valid_o (wb_valid),
    .wb_rd_o    (wb_rd),
    .wb_value_o (wb_value),
    .retire_valid_o, .retire_rd_o, .retire_value_o, .retire_ready_i
  );

  int_rf u_rf (
    .clk_i, .rst_n_i,
    .wr_valid_i  (wb_valid),
    .wr_rd_i     (wb_rd),
    .wr_value_i  (wb_value),
    .rs1_idx_i   (rs1_idx),
    .rs2_idx_i   (rs2_idx),
    .rs1_value_o (rs1_value),
    .rs2_value_o (rs2_value)
  );

endmodule

/* rtl/int_rf.sv */
`timescale 1ns/1ps

module int_rf (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // Write port from commit
  input  logic                             wr_valid_i,
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  wr_rd_i,
  input  logic [exu_pkg::XLEN-1:0]         wr_value_i,

  // Read ports toward issue
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  rs1_idx_i,
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  rs2_idx_i,
  output logic [exu_pkg::XLEN-1:0]         rs1_value_o,
  output logic [exu_pkg::XLEN-1:0]         rs2_value_o
);

  // x0 has no storage
  logic [exu_pkg::XLEN-1:0] regs_q [1:exu_pkg::XREG_NUM-1];

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < exu_pkg::XREG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_valid_i && (wr_rd_i != '0)) begin
      // Writes to x0 are dropped
      regs_q[wr_rd_i] <= wr_value_i;
    end
  end

  // ----------------------------------------
  // Read ports
  // ----------------------------------------
  // Combinational, no bypass of a same-cycle write
  always_comb begin
    rs1_value_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
    rs2_value_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];
  end

endmodule

/* rtl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // Instruction input, valid/ready
  input  logic                             instr_valid_i,
  input  exu_pkg::alu_op_e                 instr_op_i,
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  instr_rd_i,
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  instr_rs1_i,
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  instr_rs2_i,
  input  logic [exu_pkg::XLEN-1:0]         instr_imm_i,
  output logic                             instr_ready_o,

  // Write-back notice from commit
  input  logic                             wb_valid_i,
  input  logic [exu_pkg::REG_IDX_LEN-1:0]  wb_rd_i,

  // Register file reads
  output logic [exu_pkg::REG_IDX_LEN-1:0]  rs1_idx_o,
  output logic [exu_pkg::REG_IDX_LEN-1:0]  rs2_idx_o,
  input  logic [exu_pkg::XLEN-1:0]         rs1_value_i,
  input  logic [exu_pkg::XLEN-1:0]         rs2_value_i,

  // Credit link toward the ALU buffer
  output logic                             push_o,
  output exu_pkg::exec_req_t               req_o,
  input  logic                             credit_i
);

  // One bit per architectural register, bit 0 stays clear
  logic [exu_pkg::XREG_NUM-1:0]  busy_q;
  logic [exu_pkg::XREG_NUM-1:0]  busy_d;
  logic [exu_pkg::CREDIT_W-1:0]  credit_q;
  logic                          has_credit;
  logic                          hazard;
  logic                          accept;

  // ----------------------------------------
  // Acceptance
  // ----------------------------------------
  assign has_credit = (credit_q != '0);
  // Sources wait for their writer, rd waits to keep write order
  assign hazard = busy_q[instr_rs1_i] | busy_q[instr_rs2_i] | busy_q[instr_rd_i];
  assign instr_ready_o = has_credit && !hazard;
  assign accept        = instr_valid_i && instr_ready_o;

  // Operands read straight from the register file
  assign rs1_idx_o = instr_rs1_i;
  assign rs2_idx_o = instr_rs2_i;

  assign push_o    = accept;
  assign req_o.op  = instr_op_i;
  assign req_o.rd  = instr_rd_i;
  assign req_o.a   = rs1_value_i;
  assign req_o.b   = rs2_value_i;
  assign req_o.imm = instr_imm_i;

  // ----------------------------------------
  // Scoreboard
  // ----------------------------------------
  always_comb begin
    busy_d = busy_q;
    // Release on write-back
    if (wb_valid_i) begin
      busy_d[wb_rd_i] = 1'b0;
    end
    // Claim rd on issue
    if (accept) begin
      busy_d[instr_rd_i] = 1'b1;
    end
    busy_d[0] = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q   <= '0;
      credit_q <= exu_pkg::CREDIT_W'(exu_pkg::BUF_DEPTH);
    end else begin
      busy_q <= busy_d;
      // Push spends one, a returned credit gives one back
      if (push_o && !credit_i) begin
        credit_q <= credit_q - 1'b1;
      end else if (!push_o && credit_i) begin
        credit_q <= credit_q + 1'b1;
      end
    end
  end

  // Credits returned by buf_exec never exceed its depth
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_q <= exu_pkg::CREDIT_W'(exu_pkg::BUF_DEPTH))
    else $error("issue credit counter overflow");

endmodule

/* verif/tb_exu_top.sv */
`timescale 1ns/1ps

module tb_exu_top;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 16;
  localparam int RW             = exu_pkg::REG_IDX_LEN;
  localparam int XW             = exu_pkg::XLEN;
  // Accepted but not retired across buf_exec, buf_commit and the retire register
  localparam int MAX_INFLIGHT   = 2 * exu_pkg::BUF_DEPTH + 1;
  localparam int ACCEPT_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT  = 2000;
  localparam int STALL_WINDOW   = 12;
  localparam logic [31:0] SEED  = 32'he6a1_3c1d;

  logic             clk_i;
  logic             rst_n_i;
  logic             instr_valid_i;
  exu_pkg::alu_op_e instr_op_i;
  logic [RW-1:0]    instr_rd_i;
  logic [RW-1:0]    instr_rs1_i;
  logic [RW-1:0]    instr_rs2_i;
  logic [XW-1:0]    instr_imm_i;
  logic             instr_ready_o;
  logic             retire_valid_o;
  logic [RW-1:0]    retire_rd_o;
  logic [XW-1:0]    retire_value_o;
  logic             retire_ready_i;

  // Reference register model and expected retire order
  logic [XW-1:0] ref_regs [0:exu_pkg::XREG_NUM-1];
  logic [RW-1:0] exp_rd_q [$];
  logic [XW-1:0] exp_value_q [$];
  // Retire back-pressure control
  bit            ready_random;
  logic          ready_level;
  // Monitor state
  bit            stall_q;
  logic [RW-1:0] held_rd;
  logic [XW-1:0] held_value;
  logic [RW-1:0] mon_rd;
  logic [XW-1:0] mon_value;

  exu_top UUT (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ----------------------------------------
  // Reporting
  // ----------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    if (got_val !== exp_val) begin
      abort_run($sformatf("Mismatch %s exp %h got %h", name, exp_val, got_val));
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic [XW-1:0] alu_ref(input exu_pkg::alu_op_e op,
                                            input logic [XW-1:0] a, b, imm);
    logic [4:0] amount;
    // Only the low 5 bits of b shift
    amount = b[4:0];
    case (op)
      exu_pkg::OP_ADD: return a + b;
      exu_pkg::OP_SUB: return a - b;
      exu_pkg::OP_AND: return a & b;
      exu_pkg::OP_OR:  return a | b;
      exu_pkg::OP_XOR: return a ^ b;
      exu_pkg::OP_SLL: return a << amount;
      exu_pkg::OP_SRL: return a >> amount;
      default:         return imm;
    endcase
  endfunction

  // Model moves at issue and x0 keeps zero while its result still retires
  task automatic record_issue(input exu_pkg::alu_op_e op, input logic [RW-1:0] rd,
                              rs1, rs2, input logic [XW-1:0] imm);
    logic [XW-1:0] result;
    result = alu_ref(op, ref_regs[rs1], ref_regs[rs2], imm);
    exp_rd_q.push_back(rd);
    exp_value_q.push_back(result);
    if (rd != '0) begin
      ref_regs[rd] = result;
    end
  endtask

  // ----------------------------------------
  // Drivers entered and left on a falling edge
  // ----------------------------------------
  task automatic drive_ready();
    if (ready_random) begin
      retire_ready_i = ($urandom_range(3, 0) != 0);
    end else begin
      retire_ready_i = ready_level;
    end
  endtask

  task automatic drive_instr(input exu_pkg::alu_op_e op, input logic [RW-1:0] rd,
                             rs1, rs2, input logic [XW-1:0] imm);
    instr_valid_i = 1'b1;
    instr_op_i    = op;
    instr_rd_i    = rd;
    instr_rs1_i   = rs1;
    instr_rs2_i   = rs2;
    instr_imm_i   = imm;
  endtask

  // Ready sampled mid low phase and acceptance at the next rising edge
  task automatic wait_accept(input int max_cycles, output bit accepted);
    bit ready_seen;
    accepted = 1'b0;
    for (int i = 0; i < max_cycles && !accepted; i++) begin
      drive_ready();
      #(CLK_PERIOD / 4);
      ready_seen = instr_ready_o;
      @(posedge clk_i);
      accepted = ready_seen;
      if (!accepted) begin
        @(negedge clk_i);
      end
    end
  endtask

  task automatic complete_issue(input exu_pkg::alu_op_e op, input logic [RW-1:0] rd,
                                rs1, rs2, input logic [XW-1:0] imm);
    record_issue(op, rd, rs1, rs2, imm);
    @(negedge clk_i);
    instr_valid_i = 1'b0;
  endtask

  task automatic send_instr(input exu_pkg::alu_op_e op, input logic [RW-1:0] rd,
                            rs1, rs2, input logic [XW-1:0] imm);
    bit accepted;
    drive_instr(op, rd, rs1, rs2, imm);
    wait_accept(ACCEPT_TIMEOUT, accepted);
    if (!accepted) begin
      abort_run($sformatf("Instruction writing x%0d was not accepted in time", rd));
    end else begin
      complete_issue(op, rd, rs1, rs2, imm);
    end
  endtask

  task automatic wait_drain();
    for (int i = 0; i < DRAIN_TIMEOUT && exp_rd_q.size() != 0; i++) begin
      drive_ready();
      @(negedge clk_i);
    end
    if (exp_rd_q.size() != 0) begin
      abort_run("Results still outstanding after the drain timeout");
    end
  endtask

  // ----------------------------------------
  // Retire monitor
  // ----------------------------------------
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      // A stalled result must not move
      if (stall_q) begin
        check_value("retire_valid_o", 32'd1, 32'(retire_valid_o));
        check_value("retire_rd_o", 32'(held_rd), 32'(retire_rd_o));
        check_value("retire_value_o", held_value, retire_value_o);
      end
      if (retire_valid_o && retire_ready_i) begin
        if (exp_rd_q.size() == 0) begin
          abort_run("Result retired with no instruction outstanding");
        end else begin
          mon_rd    = exp_rd_q.pop_front();
          mon_value = exp_value_q.pop_front();
          check_value("retire_rd_o", 32'(mon_rd), 32'(retire_rd_o));
          check_value("retire_value_o", mon_value, retire_value_o);
        end
      end
      stall_q    = retire_valid_o && !retire_ready_i;
      held_rd    = retire_rd_o;
      held_value = retire_value_o;
    end
  end

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic idle_after_reset();
    check_value("retire_valid_o", 32'd0, 32'(retire_valid_o));
    check_value("instr_ready_o", 32'd1, 32'(instr_ready_o));
  endtask

  task automatic load_constants();
    logic [XW-1:0] imm;
    for (int r = 1; r < exu_pkg::XREG_NUM; r++) begin
      imm = (32'h0101_0101 * r) ^ 32'h5a00_00c3;
      send_instr(exu_pkg::OP_LI, RW'(r), '0, '0, imm);
    end
    wait_drain();
  endtask

  task automatic alu_ops();
    send_instr(exu_pkg::OP_LI, RW'(1), '0, '0, 32'h8000_00f1);
    // Shift amounts 36 and 0xffffffe3 keep only 4 and 3
    send_instr(exu_pkg::OP_LI, RW'(2), '0, '0, 32'h0000_0024);
    send_instr(exu_pkg::OP_LI, RW'(3), '0, '0, 32'h1234_5678);
    send_instr(exu_pkg::OP_LI, RW'(4), '0, '0, 32'hffff_ffe3);
    for (int k = 0; k < 7; k++) begin
      send_instr(exu_pkg::alu_op_e'(k), RW'(10 + k), RW'(1), RW'(2), '0);
      send_instr(exu_pkg::alu_op_e'(k), RW'(20 + k), RW'(3), RW'(4), '0);
    end
    wait_drain();
  endtask

  task automatic x0_write();
    send_instr(exu_pkg::OP_ADD, '0, RW'(1), RW'(3), '0);
    send_instr(exu_pkg::OP_ADD, RW'(5), '0, RW'(3), '0);
    send_instr(exu_pkg::OP_ADD, RW'(6), RW'(3), '0, '0);
    wait_drain();
  endtask

  task automatic dependency_chain();
    logic [RW-1:0]    prev;
    logic [RW-1:0]    rd;
    exu_pkg::alu_op_e op;
    prev = RW'(7);
    send_instr(exu_pkg::OP_LI, prev, '0, '0, 32'h0000_0013);
    for (int k = 0; k < 16; k++) begin
      rd = RW'(8 + (k % 8));
      op = (k % 3 == 0) ? exu_pkg::OP_ADD :
           (k % 3 == 1) ? exu_pkg::OP_XOR : exu_pkg::OP_SLL;
      send_instr(op, rd, prev, RW'(2), '0);
      prev = rd;
    end
    wait_drain();
  endtask

  task automatic retire_backpressure();
    int            accepted_count;
    bit            accepted;
    logic [RW-1:0] rd;
    logic [XW-1:0] imm;
    accepted_count = 0;
    accepted = 1'b1;
    ready_level = 1'b0;
    // Independent loads until issue runs out of room
    for (int k = 0; k < MAX_INFLIGHT + 1 && accepted; k++) begin
      rd  = RW'(16 + k);
      imm = 32'hb000_0000 + k;
      drive_instr(exu_pkg::OP_LI, rd, '0, '0, imm);
      wait_accept(STALL_WINDOW, accepted);
      if (accepted) begin
        accepted_count++;
        complete_issue(exu_pkg::OP_LI, rd, '0, '0, imm);
      end
    end
    if (accepted) begin
      abort_run($sformatf("instr_ready_o still high after %0d acceptances", accepted_count));
    end else begin
      // Both buffers and the retire register fill before issue stops
      check_value("accepted_count", 32'(MAX_INFLIGHT), 32'(accepted_count));
      check_value("instr_ready_o", 32'd0, 32'(instr_ready_o));
      // Pending load goes in once the retire port drains the pipe
      ready_level = 1'b1;
      wait_accept(ACCEPT_TIMEOUT, accepted);
      if (!accepted) begin
        abort_run("Stalled instruction was not accepted after retire resumed");
      end else begin
        complete_issue(exu_pkg::OP_LI, rd, '0, '0, imm);
        wait_drain();
      end
    end
  endtask

  task automatic random_stream();
    exu_pkg::alu_op_e op;
    logic [RW-1:0]    rd;
    logic [RW-1:0]    rs1;
    logic [RW-1:0]    rs2;
    ready_random = 1'b1;
    for (int n = 0; n < 200; n++) begin
      op  = exu_pkg::alu_op_e'($urandom_range(7, 0));
      rd  = RW'($urandom_range(31, 0));
      rs1 = RW'($urandom_range(31, 0));
      rs2 = RW'($urandom_range(31, 0));
      send_instr(op, rd, rs1, rs2, $urandom);
    end
    wait_drain();
    ready_random = 1'b0;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(SEED));
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    instr_valid_i  = 1'b0;
    instr_op_i     = exu_pkg::OP_ADD;
    instr_rd_i     = '0;
    instr_rs1_i    = '0;
    instr_rs2_i    = '0;
    instr_imm_i    = '0;
    retire_ready_i = 1'b1;
    ready_level    = 1'b1;
    ready_random   = 1'b0;
    stall_q        = 1'b0;
    for (int i = 0; i < exu_pkg::XREG_NUM; i++) begin
      ref_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    idle_after_reset();
    load_constants();
    alu_ops();
    x0_write();
    dependency_chain();
    retire_backpressure();
    random_stream();
    // Empty pipeline returns every credit and leaves the retire port idle
    if (!retire_valid_o && instr_ready_o) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("Pipeline not idle after the last result retired");
    end
  end

endmodule
